// ==== rtl/prot_calc.sv ====
// vector math and command response
`timescale 1ns/1ns

module prot_calc import prot_pkg::*; (
    input  logic        clk,
    input  vec_regs_t   regs,
    output logic [15:0] dout
);

    logic signed [15:0] vx0;
    logic signed [15:0] vx1;
    logic signed [15:0] vsum;
    logic signed [15:0] vs3;
    logic               rnd;
    logic [15:0]        xfield;
    logic [15:0]        sfield;
    logic [15:0]        vcalc;
    logic [15:0]        calc_q;

    always_comb begin
        // x term, negated eighth of v0 rounded by 32
        vx0    = ($signed(regs.v0) + 16'sd32) >>> 3;
        vx1    = -vx0;
        xfield = {5'd0, vx1[4:0], 6'd0};

        // s term from v1+v2, rounded toward zero
        vsum   = $signed(regs.v1) + $signed(regs.v2) - 16'sd6;
        vs3    = vsum >>> 3;
        rnd    = vsum[15] && (|vsum[2:0]);
        sfield = (16'(vs3) + {15'd0, rnd} + 16'd12) & 16'h003f;

        vcalc  = xfield + sfield;
    end

    // extra stage on the calc path, two clocks total
    always_ff @(posedge clk) begin
        calc_q <= vcalc;
    end

    // response selected by cmd, odma masked per command
    always_ff @(posedge clk) begin
        case (regs.cmd)
            CMD_ID:    dout <= RESP_ID;
            CMD_MASK4: dout <= {12'd0, regs.odma[3:0]};
            CMD_MASK5: dout <= {11'd0, regs.odma[4:0]};
            CMD_BIT0:  dout <= {15'd0, regs.odma[0]};
            CMD_BYTE0: dout <= {8'd0, regs.odma[7:0]};
            CMD_BYTE7: dout <= {8'd0, regs.odma[7:0]};
            CMD_CALC:  dout <= calc_q;
            default:   dout <= RESP_NONE;
        endcase
    end

endmodule

// ==== rtl/prot_ctrl.sv ====
// dma bus arbitration and step sequencer
`timescale 1ns/1ns

module prot_ctrl import prot_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen_8,
    input  logic       cs,
    input  logic       cpu_we,
    input  logic [7:1] trig_addr,
    input  logic       BGn,
    input  logic       level_done,
    input  logic       last_level,
    output logic       BRn,
    output logic       BGACKn,
    output logic [1:0] st,
    output logic       step_en,
    output logic       scan_start
);

    localparam logic [1:0] ST_LAST = 2'(STEPS_PER_ENTRY - 1);

    logic trig;
    logic release_bus;

    // cpu write to the trigger register
    assign trig = cs && cpu_we && (trig_addr == DMA_TRIG_ADDR);

    // scan restarts on every trigger, also mid dma
    assign scan_start = trig;

    // steps only tick while we own the bus
    assign step_en = !BGACKn && cen_8;

    // end of level 128 hands the bus back
    // a trigger in the same cycle keeps it
    assign release_bus = level_done && last_level && !trig;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            BRn    <= 1'b1;
            BGACKn <= 1'b1;
            st     <= 2'd0;
        end else begin
            // grant seen, take the bus
            if (!BGn && !BRn) begin
                BRn    <= 1'b1;
                BGACKn <= 1'b0;
            end

            if (step_en) begin
                if (st == ST_LAST) begin
                    st <= 2'd0;
                end else begin
                    st <= st + 2'd1;
                end
            end

            if (release_bus) begin
                BGACKn <= 1'b1;
                st     <= 2'd0;
            end

            if (trig) begin
                st <= 2'd0;
                // request only when idle and not already pending
                if (BGACKn && BRn) begin
                    BRn <= 1'b0;
                end
            end
        end
    end

    // request and acknowledge are never asserted together
    a_req_ack_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(!BRn && !BGACKn)
    );

    // step counter idles at 0 while the cpu owns the bus
    a_st_idle: assert property (
        @(posedge clk) disable iff (rst)
        BGACKn |-> st == 2'd0
    );

endmodule

// ==== rtl/prot_obj_scan.sv ====
// priority scan and object ram port
`timescale 1ns/1ns

module prot_obj_scan import prot_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    cpu,
    input  logic        objsys_cs,
    input  logic        BGACKn,
    input  logic [1:0]  st,
    input  logic        step_en,
    input  logic        scan_start,
    input  logic [15:0] oram_dout,
    output oram_port_t  oram,
    output logic        level_done,
    output logic        last_level
);

    localparam int         IDX_W    = $clog2(SCAN_ENTRIES);
    localparam logic [1:0] ST_WRITE = 2'(STEPS_PER_ENTRY - 1);

    logic [IDX_W-1:0]       scan_idx;
    logic [PRIO_LEVELS-1:0] level;
    logic [7:0]             rank;
    logic                   match;
    logic                   rank_wr;
    logic [13:1]            scan_addr;

    // one-hot level, last one is bit 7
    assign last_level = level[PRIO_LEVELS-1];
    assign level_done = step_en && (st == ST_WRITE) && (scan_idx == IDX_W'(SCAN_ENTRIES - 1));
    assign rank_wr    = step_en && (st == ST_WRITE) && match;

    // entries sit 8 words apart
    assign scan_addr  = {3'd0, scan_idx, 3'd0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_idx <= '0;
            level    <= PRIO_LEVELS'(1);
            rank     <= 8'd0;
            match    <= 1'b0;
        end else if (scan_start) begin
            scan_idx <= '0;
            level    <= PRIO_LEVELS'(1);
            rank     <= 8'd0;
            match    <= 1'b0;
        end else if (step_en) begin
            case (st)
                // ram data valid by step 2, address set since step 0
                2'd2: match <= (oram_dout[15:8] == level);
                ST_WRITE: begin
                    match    <= 1'b0;
                    scan_idx <= scan_idx + 1'b1;
                    if (match) begin
                        rank <= rank + 8'd1;
                    end
                    if (level_done) begin
                        level <= level << 1;
                    end
                end
                default: match <= 1'b0;
            endcase
        end
    end

    // dma owns the port while acknowledge is low
    always_comb begin
        if (!BGACKn) begin
            oram.cs   = 1'b1;
            oram.addr = obj_pin_addr(scan_addr);
            oram.din  = {8'd0, rank};
            oram.we   = {1'b0, rank_wr};
        end else begin
            oram.cs   = objsys_cs;
            oram.addr = obj_pin_addr(cpu.addr);
            oram.din  = cpu.din;
            oram.we   = ~cpu.dsn & {2{cpu.cpu_we}};
        end
    end

    // each entry matches one level at most, so ranks stay below the entry count
    a_rank_range: assert property (
        @(posedge clk) disable iff (rst)
        rank_wr |-> rank < 8'(SCAN_ENTRIES)
    );

    // cpu keeps off the object bus while the dma holds it
    a_cpu_silent: assert property (
        @(posedge clk) disable iff (rst)
        !BGACKn |-> !(objsys_cs && cpu.cpu_we)
    );

endmodule

// ==== rtl/prot_pkg.sv ====
// protection chip shared definitions
package prot_pkg;

    // register word offsets, cpu byte address minus 0x4000, halved
    localparam logic [13:1] REG_DATA = 13'hd05;
    localparam logic [13:1] REG_CMD  = 13'hc7e;
    localparam logic [13:1] REG_V0   = 13'hc0c;
    localparam logic [13:1] REG_V1   = 13'he58;
    localparam logic [13:1] REG_V2   = 13'h064;

    // dma trigger, matched on addr[7:1]
    localparam logic [7:1] DMA_TRIG_ADDR = 7'd1;

    // read port commands
    localparam logic [15:0] CMD_ID    = 16'h100b;
    localparam logic [15:0] CMD_MASK4 = 16'h6003;
    localparam logic [15:0] CMD_MASK5 = 16'h6004;
    localparam logic [15:0] CMD_BIT0  = 16'h6000;
    localparam logic [15:0] CMD_BYTE0 = 16'h0000;
    localparam logic [15:0] CMD_BYTE7 = 16'h6007;
    localparam logic [15:0] CMD_CALC  = 16'h8abc;

    localparam logic [15:0] RESP_ID   = 16'h0064;
    localparam logic [15:0] RESP_NONE = 16'hffff;

    // sort engine sizes
    localparam int SCAN_ENTRIES    = 128;
    localparam int PRIO_LEVELS     = 8;
    localparam int STEPS_PER_ENTRY = 4;

    typedef struct packed {
        logic        cs;
        logic [13:1] addr;
        logic [1:0]  dsn;
        logic [15:0] din;
        logic        cpu_we;
    } cpu_bus_t;

    typedef struct packed {
        logic        cs;
        logic [13:1] addr;
        logic [15:0] din;
        logic [1:0]  we;
    } oram_port_t;

    typedef struct packed {
        logic [15:0]        cmd;
        logic [15:0]        odma;
        logic signed [15:0] v0;
        logic signed [15:0] v1;
        logic signed [15:0] v2;
    } vec_regs_t;

    // word address reordered to match the object chip pins
    function automatic logic [13:1] obj_pin_addr(input logic [13:1] a);
        return {a[6:5], a[1], a[13:7], a[4:2]};
    endfunction

endpackage

// ==== rtl/prot_regs.sv ====
// cpu register file with byte lanes
`timescale 1ns/1ns

module prot_regs import prot_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ram_we,
    input  logic [13:1] addr,
    input  logic [1:0]  dsn,
    input  logic [15:0] din,
    output vec_regs_t   regs
);

    // merge active byte lanes, dsn is active low
    function automatic logic [15:0] lane_wr(
        input logic [15:0] old,
        input logic [15:0] wdat,
        input logic [1:0]  ben_n
    );
        logic [15:0] res;
        res = old;
        if (!ben_n[0]) begin
            res[7:0] = wdat[7:0];
        end
        if (!ben_n[1]) begin
            res[15:8] = wdat[15:8];
        end
        return res;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '0;
        end else if (ram_we) begin
            // five decoded offsets
            case (addr)
                REG_DATA: regs.odma <= lane_wr(regs.odma, din, dsn);
                REG_CMD:  regs.cmd  <= lane_wr(regs.cmd, din, dsn);
                REG_V0:   regs.v0   <= lane_wr(regs.v0, din, dsn);
                REG_V1:   regs.v1   <= lane_wr(regs.v1, din, dsn);
                REG_V2:   regs.v2   <= lane_wr(regs.v2, din, dsn);
                // shared ram elsewhere, not ours
                default: begin
                    regs <= regs;
                end
            endcase
        end
    end

endmodule

// ==== rtl/prot_top.sv ====
// protection chip top level
`timescale 1ns/1ns

module prot_top import prot_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen_8,

    // cpu side
    input  cpu_bus_t    cpu,
    input  logic        ram_we,
    input  logic        objsys_cs,
    output logic [15:0] dout,

    // object ram port
    output oram_port_t  oram,
    input  logic [15:0] oram_dout,

    // 68000 bus arbitration
    output logic        BRn,
    input  logic        BGn,
    output logic        BGACKn
);

    vec_regs_t   regs;
    logic [1:0]  st;
    logic        step_en;
    logic        scan_start;
    logic        level_done;
    logic        last_level;

    // arbitration and step sequencing
    prot_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cen_8      (cen_8),
        .cs         (cpu.cs),
        .cpu_we     (cpu.cpu_we),
        .trig_addr  (cpu.addr[7:1]),
        .BGn        (BGn),
        .level_done (level_done),
        .last_level (last_level),
        .BRn        (BRn),
        .BGACKn     (BGACKn),
        .st         (st),
        .step_en    (step_en),
        .scan_start (scan_start)
    );

    // written through the shared ram strobe
    prot_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .ram_we (ram_we),
        .addr   (cpu.addr),
        .dsn    (cpu.dsn),
        .din    (cpu.din),
        .regs   (regs)
    );

    prot_calc u_calc (
        .clk  (clk),
        .regs (regs),
        .dout (dout)
    );

    // priority scan and object ram mux
    prot_obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .cpu        (cpu),
        .objsys_cs  (objsys_cs),
        .BGACKn     (BGACKn),
        .st         (st),
        .step_en    (step_en),
        .scan_start (scan_start),
        .oram_dout  (oram_dout),
        .oram       (oram),
        .level_done (level_done),
        .last_level (last_level)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the protection chip testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -F "TESTS PASSED" > /dev/null \
    && echo "simulation ok" \
    && exit 0

echo "simulation not ok" || true
exit 1

// ==== sources.f ====
rtl/prot_pkg.sv
rtl/prot_ctrl.sv
rtl/prot_regs.sv
rtl/prot_calc.sv
rtl/prot_obj_scan.sv
rtl/prot_top.sv
test/tb_checker.sv
test/tb_top.sv

// ==== test/tb_checker.sv ====
// protection chip result checker
`timescale 1ns/1ns

module tb_checker import prot_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen_8,
    input  logic [15:0] dout,
    input  oram_port_t  oram,
    input  logic        BRn,
    input  logic        BGACKn,
    output logic        timed_out
);

    // two full dmas plus register and cpu write tests
    localparam int DMA_CLOCKS     = SCAN_ENTRIES * PRIO_LEVELS * STEPS_PER_ENTRY * 2;
    localparam int TIMEOUT_CLOCKS = 2 * DMA_CLOCKS + 3616;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          wr_count;
    int          dma_ticks;
    int          test_mark;
    logic [15:0] pre_img [0:SCAN_ENTRIES-1];
    logic [12:0] obj_addr;
    logic [15:0] obj_exp;

    // object chip pin order, bit 1 of the word address is index 0
    function automatic logic [12:0] pin_order(input logic [12:0] w);
        return {w[5:4], w[0], w[12:6], w[3:1]};
    endfunction

    function automatic logic [15:0] merge_lanes(
        input logic [15:0] old,
        input logic [15:0] wdat,
        input logic [1:0]  dsn_n
    );
        logic [15:0] res;
        res = old;
        if (!dsn_n[0]) res[7:0] = wdat[7:0];
        if (!dsn_n[1]) res[15:8] = wdat[15:8];
        return res;
    endfunction

    // trunc toward zero for the s term, floor for x
    function automatic logic [15:0] calc_ref(input logic [15:0] v0, v1, v2);
        int          t;
        int          x;
        int          s;
        logic [15:0] sum16;
        t     = int'($signed(v0 + 16'd32));
        x     = -(t >>> 3);
        sum16 = v1 + v2 - 16'd6;
        s     = (int'($signed(sum16)) / 8 + 12) & 63;
        return 16'((x & 31) << 6) + 16'(s);
    endfunction

    function automatic logic [15:0] resp_ref(input logic [15:0] cmd, odma, calc);
        case (cmd)
            CMD_ID:    return RESP_ID;
            CMD_MASK4: return {12'd0, odma[3:0]};
            CMD_MASK5: return {11'd0, odma[4:0]};
            CMD_BIT0:  return {15'd0, odma[0]};
            CMD_BYTE0: return {8'd0, odma[7:0]};
            CMD_BYTE7: return {8'd0, odma[7:0]};
            CMD_CALC:  return calc;
            default:   return RESP_NONE;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic begin_test();
        test_mark = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_mark) $display("PASS %s", name);
        else $display("FAIL %s: %0d errors", name, errors - test_mark);
    endtask

    task automatic check_idle();
        begin_test();
        check_val("reset BRn", 16'd1, {15'd0, BRn});
        check_val("reset BGACKn", 16'd1, {15'd0, BGACKn});
        check_val("reset oram writes", 16'd0, 16'(wr_count));
        end_test("reset state");
    endtask

    task automatic check_resp(input string name, input logic [15:0] cmd, odma, v0, v1, v2);
        check_val(name, resp_ref(cmd, odma, calc_ref(v0, v1, v2)), dout);
    endtask

    // 4 steps per entry, 128 entries per level, 8 levels
    task automatic check_dma_steps();
        check_val("dma steps", 16'(SCAN_ENTRIES * PRIO_LEVELS * STEPS_PER_ENTRY),
                  16'(dma_ticks));
    endtask

    task automatic load_entry(input int idx, input logic [15:0] v);
        pre_img[idx] = v;
    endtask

    // levels 1 to 128 in turn, entries in index order, consecutive ranks
    task automatic check_sort();
        logic [15:0] exp_img [0:SCAN_ENTRIES-1];
        int          rank;
        rank = 0;
        for (int e = 0; e < SCAN_ENTRIES; e++) exp_img[e] = pre_img[e];
        for (int l = 0; l < PRIO_LEVELS; l++) begin
            for (int e = 0; e < SCAN_ENTRIES; e++) begin
                if (pre_img[e][15:8] == 8'(1 << l)) begin
                    exp_img[e][7:0] = 8'(rank);
                    rank++;
                end
            end
        end
        for (int e = 0; e < SCAN_ENTRIES; e++) begin
            check_val($sformatf("sort entry %0d", e), exp_img[e],
                      tb_top.oram_mem[pin_order({3'd0, 7'(e), 3'd0})]);
        end
    endtask

    // snapshot before the write edge
    task automatic expect_obj_write(input logic [12:0] a, input logic [1:0] dsn_n,
                                    input logic [15:0] d);
        obj_addr = a;
        obj_exp  = merge_lanes(tb_top.oram_mem[pin_order(a)], d, dsn_n);
    endtask

    task automatic check_obj_write(input string name);
        check_val(name, obj_exp, tb_top.oram_mem[pin_order(obj_addr)]);
    endtask

    task automatic report_counts();
        $display("%0d checks, %0d errors", checks, errors);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            timed_out <= 1'b0;
            wr_count  <= 0;
            dma_ticks <= 0;
        end else begin
            cycles <= cycles + 1;
            if (oram.cs && |oram.we) wr_count <= wr_count + 1;
            // cen_8 ticks while the bus is held
            if (!BGACKn && cen_8) dma_ticks <= dma_ticks + 1;
            if (!BRn && !BGACKn) begin
                errors++;
                $display("error: BRn and BGACKn low together at clock %0d", cycles);
            end
            if (!BGACKn && oram.we[1]) begin
                errors++;
                $display("error: high byte written during dma at clock %0d", cycles);
            end
            if (cycles == TIMEOUT_CLOCKS) begin
                $display("timeout: no end of run after %0d clocks, BRn=%b BGACKn=%b",
                         cycles, BRn, BGACKn);
                timed_out <= 1'b1;
            end
        end
    end

endmodule

// ==== test/tb_top.sv ====
// protection chip testbench
`timescale 1ns/1ns

module tb_top import prot_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst;
    logic        cen_8 = 1'b0;
    cpu_bus_t    cpu;
    logic        ram_we;
    logic        objsys_cs;
    logic [15:0] dout;
    oram_port_t  oram;
    logic [15:0] oram_dout = 16'h0000;
    logic        BRn;
    logic        BGn;
    logic        BGACKn;
    logic        timed_out;
    logic        fill_req;
    logic [31:0] lfsr_state = 32'h9510dad2;
    logic [15:0] oram_mem  [0:8191];
    logic [15:0] entry_img [0:SCAN_ENTRIES-1];

    always #4 clk = ~clk;

    // 8 unit enable, every other clock
    always @(negedge clk) cen_8 <= ~cen_8;

    prot_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .cen_8     (cen_8),
        .cpu       (cpu),
        .ram_we    (ram_we),
        .objsys_cs (objsys_cs),
        .dout      (dout),
        .oram      (oram),
        .oram_dout (oram_dout),
        .BRn       (BRn),
        .BGn       (BGn),
        .BGACKn    (BGACKn)
    );

    tb_checker i_chk (
        .clk       (clk),
        .rst       (rst),
        .cen_8     (cen_8),
        .dout      (dout),
        .oram      (oram),
        .BRn       (BRn),
        .BGACKn    (BGACKn),
        .timed_out (timed_out)
    );

    // object ram model, one clock read latency
    always @(posedge clk) begin
        if (fill_req) begin
            for (int a = 0; a < 8192; a++) oram_mem[a] <= {3'b101, 13'(a)};
            for (int e = 0; e < SCAN_ENTRIES; e++) begin
                oram_mem[i_chk.pin_order({3'd0, 7'(e), 3'd0})] <= entry_img[e];
            end
        end else if (oram.cs) begin
            if (oram.we[0]) oram_mem[oram.addr][7:0] <= oram.din[7:0];
            if (oram.we[1]) oram_mem[oram.addr][15:8] <= oram.din[15:8];
        end
        oram_dout <= oram_mem[oram.addr];
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [15:0] get_bits(input int n);
        logic        fb;
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb         = ^(lfsr_state & 32'h80200003);
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[14:0], fb};
        end
        return v;
    endfunction

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    // called on a falling edge, leaves on the next one
    task automatic write_reg(input logic [13:1] a, input logic [1:0] dsn_n,
                             input logic [15:0] d);
        cpu.addr = a;
        cpu.dsn  = dsn_n;
        cpu.din  = d;
        ram_we   = 1'b1;
        @(negedge clk);
        ram_we   = 1'b0;
    endtask

    // bus grant after 1 to 8 clocks, dropped once BRn rises
    initial begin
        logic [15:0] r;
        BGn = 1'b1;
        forever begin
            @(negedge clk);
            if (!BRn) begin
                r = get_bits(3);
                repeat (int'(r[2:0]) + 1) @(negedge clk);
                BGn = 1'b0;
                while (!BRn) @(negedge clk);
                BGn = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (timed_out) begin
            i_chk.report_counts();
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [15:0] r;
        logic [15:0] a;
        logic [15:0] d;
        logic [15:0] v0;
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] odma;
        logic [15:0] cmds [0:6];
        rst       = 1'b1;
        cpu       = '0;
        ram_we    = 1'b0;
        objsys_cs = 1'b0;
        fill_req  = 1'b0;
        cmds      = '{CMD_ID, CMD_MASK4, CMD_MASK5, CMD_BIT0, CMD_BYTE0, CMD_BYTE7, 16'h1234};
        wait_clocks(8);
        rst = 1'b0;
        wait_clocks(4);
        i_chk.check_idle();

        // priority byte one-hot or zero, random low byte
        for (int i = 0; i < SCAN_ENTRIES; i++) begin
            r = get_bits(4);
            d = get_bits(8);
            entry_img[i] = {r[3] ? 8'(1 << r[2:0]) : 8'd0, d[7:0]};
            i_chk.load_entry(i, entry_img[i]);
        end
        fill_req = 1'b1;
        @(negedge clk);
        fill_req = 1'b0;

        // byte lanes then each odma command
        i_chk.begin_test();
        odma = 16'h0000;
        write_reg(REG_DATA, 2'b10, 16'h77b5);
        odma = i_chk.merge_lanes(odma, 16'h77b5, 2'b10);
        write_reg(REG_DATA, 2'b01, 16'h3c11);
        odma = i_chk.merge_lanes(odma, 16'h3c11, 2'b01);
        for (int i = 0; i < 7; i++) begin
            write_reg(REG_CMD, 2'b00, cmds[i]);
            wait_clocks(3);
            i_chk.check_resp($sformatf("resp %h", cmds[i]), cmds[i], odma, 16'd0, 16'd0, 16'd0);
        end
        i_chk.end_test("odma responses");

        i_chk.begin_test();
        write_reg(REG_CMD, 2'b00, CMD_CALC);
        for (int i = 0; i < 30; i++) begin
            v0 = get_bits(16);
            v1 = get_bits(16);
            v2 = get_bits(16);
            write_reg(REG_V0, 2'b00, v0);
            write_reg(REG_V1, 2'b00, v1);
            write_reg(REG_V2, 2'b00, v2);
            wait_clocks(3);
            i_chk.check_resp($sformatf("calc %0d", i), CMD_CALC, odma, v0, v1, v2);
        end
        i_chk.end_test("vector calc");

        // trigger write, addr[7:1] == 1
        i_chk.begin_test();
        cpu.addr   = 13'h0001;
        cpu.cs     = 1'b1;
        cpu.cpu_we = 1'b1;
        @(negedge clk);
        cpu.cs     = 1'b0;
        cpu.cpu_we = 1'b0;
        i_chk.check_val("dma request", 16'd0, {15'd0, BRn});
        while (BGACKn) @(negedge clk);
        i_chk.check_val("request dropped", 16'd1, {15'd0, BRn});
        while (!BGACKn) @(negedge clk);
        // release only after the last step of level 128
        i_chk.check_dma_steps();
        i_chk.end_test("dma handshake");

        i_chk.begin_test();
        i_chk.check_sort();
        i_chk.end_test("priority sort");

        // cpu writes through objsys_cs, both lanes, one or the other
        i_chk.begin_test();
        for (int i = 0; i < 8; i++) begin
            a = get_bits(13);
            r = get_bits(2);
            if (r[1:0] == 2'b11) r = 16'd0;
            d = get_bits(16);
            i_chk.expect_obj_write(a[12:0], r[1:0], d);
            cpu.addr   = a[12:0];
            cpu.dsn    = r[1:0];
            cpu.din    = d;
            cpu.cpu_we = 1'b1;
            objsys_cs  = 1'b1;
            @(negedge clk);
            objsys_cs  = 1'b0;
            cpu.cpu_we = 1'b0;
            @(negedge clk);
            i_chk.check_obj_write($sformatf("obj write %0d", i));
        end
        i_chk.end_test("cpu object writes");

        i_chk.report_counts();
        if (i_chk.errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
